// ==== wb_cache_config.svh ====
`ifndef WB_CACHE_CONFIG_SVH
`define WB_CACHE_CONFIG_SVH

// front-end word address, msb selects the control space
`define WB_CACHE_ADDR_W 12
`define WB_CACHE_DATA_W 32
`define WB_CACHE_SEL_W 4

// 16 lines of 4 words
`define WB_CACHE_LINES_W 4
`define WB_CACHE_OFFSET_W 2

// tag covers what is left of the memory-space address
`define WB_CACHE_TAG_W (`WB_CACHE_ADDR_W - 1 - `WB_CACHE_LINES_W - `WB_CACHE_OFFSET_W)

// write-through buffer holds 2**n entries
`define WB_CACHE_WTBUF_DEPTH_W 2

`endif

// ==== wb_cache_pkg.sv ====
`default_nettype none

package wb_cache_pkg;

   // cache memory FSM
   typedef enum logic [2:0] {
      IDLE,
      LOOKUP,
      WAIT_WTBUF,
      REFILL,
      RESPOND
   } cache_state_e;

   // control space word addresses, the last two are write commands
   typedef enum logic [2:0] {
      STATUS,
      READ_HIT,
      READ_MISS,
      WRITE_HIT,
      WRITE_MISS,
      INVALIDATE,
      CLEAR_CNT
   } ctrl_reg_e;

endpackage

`default_nettype wire

// ==== wb_cache_if.sv ====
`default_nettype none
`include "wb_cache_config.svh"

// front end to cache memory or control block
interface cache_req_if;
   logic                          req;
   logic                          we;
   logic [`WB_CACHE_ADDR_W-2:0]   addr;
   logic [`WB_CACHE_DATA_W-1:0]   wdata;
   logic [`WB_CACHE_SEL_W-1:0]    sel;
   logic [`WB_CACHE_DATA_W-1:0]   rdata;
   logic                          ack;

   modport master (output req, we, addr, wdata, sel, input rdata, ack);
   modport slave (input req, we, addr, wdata, sel, output rdata, ack);
endinterface

// refill or drain channel into the back-end arbiter
interface cache_bus_if;
   logic                          req;
   logic                          we;
   logic [`WB_CACHE_ADDR_W-2:0]   addr;
   logic [`WB_CACHE_DATA_W-1:0]   wdata;
   logic [`WB_CACHE_SEL_W-1:0]    sel;
   logic [`WB_CACHE_DATA_W-1:0]   rdata;
   logic                          ack;

   modport master (output req, we, addr, wdata, sel, input rdata, ack);
   modport slave (input req, we, addr, wdata, sel, output rdata, ack);
endinterface

`default_nettype wire

// ==== wb_cache_front_end.sv ====
`default_nettype none
`include "wb_cache_config.svh"

module wb_cache_front_end (
   input  wire                          clk_i,
   input  wire                          arst_n_i,
   input  wire                          cyc_i,
   input  wire                          stb_i,
   input  wire                          we_i,
   input  wire  [`WB_CACHE_ADDR_W-1:0]  adr_i,
   input  wire  [`WB_CACHE_DATA_W-1:0]  dat_i,
   input  wire  [`WB_CACHE_SEL_W-1:0]   sel_i,
   output logic [`WB_CACHE_DATA_W-1:0]  dat_o,
   output logic                         ack_o,
   cache_req_if.master                  mem,
   cache_req_if.master                  ctrl
);

   logic                          busy_q;
   logic                          to_ctrl_q;
   logic                          we_q;
   logic [`WB_CACHE_ADDR_W-2:0]   addr_q;
   logic [`WB_CACHE_DATA_W-1:0]   data_q;
   logic [`WB_CACHE_SEL_W-1:0]    sel_q;
   logic                          slave_ack;
   logic [`WB_CACHE_DATA_W-1:0]   slave_rdata;

   assign slave_ack   = to_ctrl_q ? ctrl.ack : mem.ack;
   assign slave_rdata = to_ctrl_q ? ctrl.rdata : mem.rdata;

   // one request in flight, no new strobe taken while ack_o is up
   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         busy_q    <= 1'b0;
         to_ctrl_q <= 1'b0;
         ack_o     <= 1'b0;
      end else begin
         ack_o <= busy_q && slave_ack;
         if (busy_q) begin
            if (slave_ack) begin
               busy_q <= 1'b0;
            end
         end else if (cyc_i && stb_i && !ack_o) begin
            busy_q    <= 1'b1;
            to_ctrl_q <= adr_i[`WB_CACHE_ADDR_W-1];
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (!busy_q) begin
         we_q   <= we_i;
         addr_q <= adr_i[`WB_CACHE_ADDR_W-2:0];
         data_q <= dat_i;
         sel_q  <= sel_i;
      end
      if (busy_q && slave_ack) begin
         dat_o <= slave_rdata;
      end
   end

   // msb of the address picks the target
   assign mem.req   = busy_q && !to_ctrl_q;
   assign mem.we    = we_q;
   assign mem.addr  = addr_q;
   assign mem.wdata = data_q;
   assign mem.sel   = sel_q;

   assign ctrl.req   = busy_q && to_ctrl_q;
   assign ctrl.we    = we_q;
   assign ctrl.addr  = addr_q;
   assign ctrl.wdata = data_q;
   assign ctrl.sel   = sel_q;

endmodule

`default_nettype wire

// ==== wb_cache_memory.sv ====
`default_nettype none
`include "wb_cache_config.svh"

module wb_cache_memory (
   input  wire                          clk_i,
   input  wire                          arst_n_i,
   cache_req_if.slave                   req,
   cache_bus_if.master                  refill,
   output logic                         wtb_push_o,
   output logic [`WB_CACHE_ADDR_W-2:0]  wtb_addr_o,
   output logic [`WB_CACHE_DATA_W-1:0]  wtb_data_o,
   output logic [`WB_CACHE_SEL_W-1:0]   wtb_sel_o,
   input  wire                          wtb_full_i,
   input  wire                          wtb_empty_i,
   output logic                         read_hit_o,
   output logic                         read_miss_o,
   output logic                         write_hit_o,
   output logic                         write_miss_o,
   input  wire                          invalidate_i
);

   import wb_cache_pkg::*;

   cache_state_e                        state_q;
   logic [(1<<`WB_CACHE_LINES_W)-1:0]   valid_q;
   logic [`WB_CACHE_TAG_W-1:0]          tag_mem [0:(1<<`WB_CACHE_LINES_W)-1];
   logic [`WB_CACHE_DATA_W-1:0]
      data_mem [0:(1<<(`WB_CACHE_LINES_W+`WB_CACHE_OFFSET_W))-1];

   logic [`WB_CACHE_TAG_W-1:0]          req_tag;
   logic [`WB_CACHE_LINES_W-1:0]        req_idx;
   logic [`WB_CACHE_OFFSET_W-1:0]       req_off;
   logic [`WB_CACHE_OFFSET_W-1:0]       fill_cnt_q;
   logic                                hit;
   logic                                lookup;
   logic                                fill_ack;
   logic                                fill_last;
   logic                                ack_q;
   logic [`WB_CACHE_DATA_W-1:0]         rdata_q;

   assign {req_tag, req_idx, req_off} = req.addr;
   assign hit    = valid_q[req_idx] && (tag_mem[req_idx] == req_tag);
   assign lookup = (state_q == LOOKUP) && req.req;

   assign fill_ack  = (state_q == REFILL) && refill.ack;
   assign fill_last = fill_ack && (&fill_cnt_q);

   // every accepted write goes to the buffer, a full buffer stalls it
   assign wtb_push_o = lookup && req.we && !wtb_full_i;
   assign wtb_addr_o = req.addr;
   assign wtb_data_o = req.wdata;
   assign wtb_sel_o  = req.sel;

   assign read_hit_o   = lookup && !req.we && hit;
   assign read_miss_o  = lookup && !req.we && !hit;
   assign write_hit_o  = wtb_push_o && hit;
   assign write_miss_o = wtb_push_o && !hit;

   // line refill, words fetched in order from offset 0
   assign refill.req   = (state_q == REFILL);
   assign refill.we    = 1'b0;
   assign refill.addr  = {req_tag, req_idx, fill_cnt_q};
   assign refill.wdata = '0;
   assign refill.sel   = '1;

   assign req.ack   = ack_q;
   assign req.rdata = rdata_q;

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state_q    <= IDLE;
         fill_cnt_q <= '0;
         ack_q      <= 1'b0;
      end else begin
         ack_q <= 1'b0;
         case (state_q)
            IDLE: state_q <= LOOKUP;
            LOOKUP: begin
               if (read_hit_o || wtb_push_o) begin
                  ack_q   <= 1'b1;
                  state_q <= RESPOND;
               end else if (read_miss_o) begin
                  state_q <= WAIT_WTBUF;
               end
            end
            // refill must not overtake pending writes
            WAIT_WTBUF: begin
               if (wtb_empty_i) begin
                  fill_cnt_q <= '0;
                  state_q    <= REFILL;
               end
            end
            REFILL: begin
               if (fill_ack) begin
                  fill_cnt_q <= fill_cnt_q + 1'b1;
               end
               if (fill_last) begin
                  ack_q   <= 1'b1;
                  state_q <= RESPOND;
               end
            end
            // request drops while here
            RESPOND: state_q <= LOOKUP;
            default: state_q <= IDLE;
         endcase
      end
   end

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         valid_q <= '0;
      end else if (invalidate_i) begin
         valid_q <= '0;
      end else if (fill_last) begin
         valid_q[req_idx] <= 1'b1;
      end
   end

   always_ff @(posedge clk_i) begin
      if (fill_ack) begin
         data_mem[{req_idx, fill_cnt_q}] <= refill.rdata;
      end
      if (fill_last) begin
         tag_mem[req_idx] <= req_tag;
      end
      // byte merge on a write hit
      if (write_hit_o) begin
         for (int b = 0; b < `WB_CACHE_SEL_W; b++) begin
            if (req.sel[b]) begin
               data_mem[{req_idx, req_off}][8*b +: 8] <= req.wdata[8*b +: 8];
            end
         end
      end
      if (read_hit_o) begin
         rdata_q <= data_mem[{req_idx, req_off}];
      end else if (fill_ack && (fill_cnt_q == req_off)) begin
         rdata_q <= refill.rdata;
      end
   end

endmodule

`default_nettype wire

// ==== wb_cache_wtbuf.sv ====
`default_nettype none
`include "wb_cache_config.svh"

module wb_cache_wtbuf (
   input  wire                          clk_i,
   input  wire                          arst_n_i,
   input  wire                          push_i,
   input  wire  [`WB_CACHE_ADDR_W-2:0]  addr_i,
   input  wire  [`WB_CACHE_DATA_W-1:0]  data_i,
   input  wire  [`WB_CACHE_SEL_W-1:0]   sel_i,
   output logic                         full_o,
   output logic                         empty_o,
   cache_bus_if.master                  drain
);

   logic [`WB_CACHE_ADDR_W-2:0]  addr_mem [0:(1<<`WB_CACHE_WTBUF_DEPTH_W)-1];
   logic [`WB_CACHE_DATA_W-1:0]  data_mem [0:(1<<`WB_CACHE_WTBUF_DEPTH_W)-1];
   logic [`WB_CACHE_SEL_W-1:0]   sel_mem [0:(1<<`WB_CACHE_WTBUF_DEPTH_W)-1];

   // one extra bit tells full from empty
   logic [`WB_CACHE_WTBUF_DEPTH_W:0]    wr_ptr_q;
   logic [`WB_CACHE_WTBUF_DEPTH_W:0]    rd_ptr_q;
   logic [`WB_CACHE_WTBUF_DEPTH_W-1:0]  head;

   assign head    = rd_ptr_q[`WB_CACHE_WTBUF_DEPTH_W-1:0];
   assign empty_o = (wr_ptr_q == rd_ptr_q);
   assign full_o  = (wr_ptr_q[`WB_CACHE_WTBUF_DEPTH_W] != rd_ptr_q[`WB_CACHE_WTBUF_DEPTH_W])
                 && (wr_ptr_q[`WB_CACHE_WTBUF_DEPTH_W-1:0] == head);

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
      end else begin
         if (push_i) begin
            wr_ptr_q <= wr_ptr_q + 1'b1;
         end
         // pop once the head write is acked
         if (drain.ack) begin
            rd_ptr_q <= rd_ptr_q + 1'b1;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (push_i) begin
         addr_mem[wr_ptr_q[`WB_CACHE_WTBUF_DEPTH_W-1:0]] <= addr_i;
         data_mem[wr_ptr_q[`WB_CACHE_WTBUF_DEPTH_W-1:0]] <= data_i;
         sel_mem[wr_ptr_q[`WB_CACHE_WTBUF_DEPTH_W-1:0]]  <= sel_i;
      end
   end

   assign drain.req   = !empty_o;
   assign drain.we    = 1'b1;
   assign drain.addr  = addr_mem[head];
   assign drain.wdata = data_mem[head];
   assign drain.sel   = sel_mem[head];

endmodule

`default_nettype wire

// ==== wb_cache_back_end.sv ====
`default_nettype none
`include "wb_cache_config.svh"

module wb_cache_back_end (
   input  wire                          clk_i,
   input  wire                          arst_n_i,
   cache_bus_if.slave                   refill,
   cache_bus_if.slave                   drain,
   output logic                         m_cyc_o,
   output logic                         m_stb_o,
   output logic                         m_we_o,
   output logic [`WB_CACHE_ADDR_W-2:0]  m_adr_o,
   output logic [`WB_CACHE_DATA_W-1:0]  m_dat_o,
   output logic [`WB_CACHE_SEL_W-1:0]   m_sel_o,
   input  wire  [`WB_CACHE_DATA_W-1:0]  m_dat_i,
   input  wire                          m_ack_i
);

   logic gnt_drain_q;
   logic done;

   assign done = m_stb_o && m_ack_i;

   // drain first, grant held until the slave acks
   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         m_cyc_o     <= 1'b0;
         m_stb_o     <= 1'b0;
         gnt_drain_q <= 1'b0;
      end else if (m_stb_o) begin
         if (m_ack_i) begin
            m_cyc_o <= 1'b0;
            m_stb_o <= 1'b0;
         end
      end else if (drain.req) begin
         m_cyc_o     <= 1'b1;
         m_stb_o     <= 1'b1;
         gnt_drain_q <= 1'b1;
      end else if (refill.req) begin
         m_cyc_o     <= 1'b1;
         m_stb_o     <= 1'b1;
         gnt_drain_q <= 1'b0;
      end
   end

   // transfer fields frozen while the strobe is up
   always_ff @(posedge clk_i) begin
      if (!m_stb_o) begin
         if (drain.req) begin
            m_we_o  <= drain.we;
            m_adr_o <= drain.addr;
            m_dat_o <= drain.wdata;
            m_sel_o <= drain.sel;
         end else begin
            m_we_o  <= refill.we;
            m_adr_o <= refill.addr;
            m_dat_o <= refill.wdata;
            m_sel_o <= refill.sel;
         end
      end
   end

   assign drain.ack    = done && gnt_drain_q;
   assign refill.ack   = done && !gnt_drain_q;
   assign drain.rdata  = gnt_drain_q ? m_dat_i : '0;
   assign refill.rdata = gnt_drain_q ? '0 : m_dat_i;

endmodule

`default_nettype wire

// ==== wb_cache_control.sv ====
`default_nettype none
`include "wb_cache_config.svh"

module wb_cache_control (
   input  wire   clk_i,
   input  wire   arst_n_i,
   cache_req_if.slave ctrl,
   input  wire   read_hit_i,
   input  wire   read_miss_i,
   input  wire   write_hit_i,
   input  wire   write_miss_i,
   input  wire   wtb_empty_i,
   input  wire   wtb_full_i,
   output logic  invalidate_o
);

   import wb_cache_pkg::*;

   ctrl_reg_e                    reg_sel;
   logic [`WB_CACHE_DATA_W-1:0]  cnt_q [0:3];
   logic [3:0]                   cnt_inc;
   logic                         access;
   logic                         clear;
   logic                         ack_q;
   logic [`WB_CACHE_DATA_W-1:0]  rd_word;
   logic [`WB_CACHE_DATA_W-1:0]  rdata_q;

   assign reg_sel = ctrl_reg_e'(ctrl.addr[$bits(ctrl_reg_e)-1:0]);
   // request stays up through the ack cycle
   assign access  = ctrl.req && !ack_q;
   assign clear   = access && ctrl.we && (reg_sel == CLEAR_CNT);
   assign cnt_inc = {write_miss_i, write_hit_i, read_miss_i, read_hit_i};

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         for (int i = 0; i < 4; i++) begin
            cnt_q[i] <= '0;
         end
      end else if (clear) begin
         for (int i = 0; i < 4; i++) begin
            cnt_q[i] <= '0;
         end
      end else begin
         // counters stick at all ones
         for (int i = 0; i < 4; i++) begin
            if (cnt_inc[i] && !(&cnt_q[i])) begin
               cnt_q[i] <= cnt_q[i] + 1'b1;
            end
         end
      end
   end

   always_comb begin
      case (reg_sel)
         STATUS:     rd_word = {{(`WB_CACHE_DATA_W-2){1'b0}}, wtb_full_i, wtb_empty_i};
         READ_HIT:   rd_word = cnt_q[0];
         READ_MISS:  rd_word = cnt_q[1];
         WRITE_HIT:  rd_word = cnt_q[2];
         WRITE_MISS: rd_word = cnt_q[3];
         default:    rd_word = '0;
      endcase
   end

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         ack_q        <= 1'b0;
         invalidate_o <= 1'b0;
      end else begin
         ack_q        <= access;
         invalidate_o <= access && ctrl.we && (reg_sel == INVALIDATE);
      end
   end

   always_ff @(posedge clk_i) begin
      if (access) begin
         rdata_q <= rd_word;
      end
   end

   assign ctrl.ack   = ack_q;
   assign ctrl.rdata = rdata_q;

endmodule

`default_nettype wire

// ==== wb_cache_top.sv ====
`default_nettype none
`include "wb_cache_config.svh"

module wb_cache_top (
   input  wire                          clk_i,
   input  wire                          arst_n_i,
   // front-end slave
   input  wire                          cyc_i,
   input  wire                          stb_i,
   input  wire                          we_i,
   input  wire  [`WB_CACHE_ADDR_W-1:0]  adr_i,
   input  wire  [`WB_CACHE_DATA_W-1:0]  dat_i,
   input  wire  [`WB_CACHE_SEL_W-1:0]   sel_i,
   output wire  [`WB_CACHE_DATA_W-1:0]  dat_o,
   output wire                          ack_o,
   // back-end master
   output wire                          m_cyc_o,
   output wire                          m_stb_o,
   output wire                          m_we_o,
   output wire  [`WB_CACHE_ADDR_W-2:0]  m_adr_o,
   output wire  [`WB_CACHE_DATA_W-1:0]  m_dat_o,
   output wire  [`WB_CACHE_SEL_W-1:0]   m_sel_o,
   input  wire  [`WB_CACHE_DATA_W-1:0]  m_dat_i,
   input  wire                          m_ack_i
);

   cache_req_if mem_req ();
   cache_req_if ctrl_req ();
   cache_bus_if refill ();
   cache_bus_if drain ();

   wire                          wtb_push;
   wire [`WB_CACHE_ADDR_W-2:0]   wtb_addr;
   wire [`WB_CACHE_DATA_W-1:0]   wtb_data;
   wire [`WB_CACHE_SEL_W-1:0]    wtb_sel;
   wire                          wtb_full;
   wire                          wtb_empty;
   wire                          read_hit;
   wire                          read_miss;
   wire                          write_hit;
   wire                          write_miss;
   wire                          invalidate;

   wb_cache_front_end front_end (
      .clk_i    (clk_i),
      .arst_n_i (arst_n_i),
      .cyc_i    (cyc_i),
      .stb_i    (stb_i),
      .we_i     (we_i),
      .adr_i    (adr_i),
      .dat_i    (dat_i),
      .sel_i    (sel_i),
      .dat_o    (dat_o),
      .ack_o    (ack_o),
      .mem      (mem_req),
      .ctrl     (ctrl_req)
   );

   wb_cache_memory cache_memory (
      .clk_i        (clk_i),
      .arst_n_i     (arst_n_i),
      .req          (mem_req),
      .refill       (refill),
      .wtb_push_o   (wtb_push),
      .wtb_addr_o   (wtb_addr),
      .wtb_data_o   (wtb_data),
      .wtb_sel_o    (wtb_sel),
      .wtb_full_i   (wtb_full),
      .wtb_empty_i  (wtb_empty),
      .read_hit_o   (read_hit),
      .read_miss_o  (read_miss),
      .write_hit_o  (write_hit),
      .write_miss_o (write_miss),
      .invalidate_i (invalidate)
   );

   wb_cache_wtbuf wtbuf (
      .clk_i    (clk_i),
      .arst_n_i (arst_n_i),
      .push_i   (wtb_push),
      .addr_i   (wtb_addr),
      .data_i   (wtb_data),
      .sel_i    (wtb_sel),
      .full_o   (wtb_full),
      .empty_o  (wtb_empty),
      .drain    (drain)
   );

   wb_cache_back_end back_end (
      .clk_i    (clk_i),
      .arst_n_i (arst_n_i),
      .refill   (refill),
      .drain    (drain),
      .m_cyc_o  (m_cyc_o),
      .m_stb_o  (m_stb_o),
      .m_we_o   (m_we_o),
      .m_adr_o  (m_adr_o),
      .m_dat_o  (m_dat_o),
      .m_sel_o  (m_sel_o),
      .m_dat_i  (m_dat_i),
      .m_ack_i  (m_ack_i)
   );

   wb_cache_control cache_control (
      .clk_i        (clk_i),
      .arst_n_i     (arst_n_i),
      .ctrl         (ctrl_req),
      .read_hit_i   (read_hit),
      .read_miss_i  (read_miss),
      .write_hit_i  (write_hit),
      .write_miss_i (write_miss),
      .wtb_empty_i  (wtb_empty),
      .wtb_full_i   (wtb_full),
      .invalidate_o (invalidate)
   );

endmodule

`default_nettype wire

// ==== wb_cache_sva.sv ====
`default_nettype none
`include "wb_cache_config.svh"

module wb_cache_sva (
   input wire                          clk_i,
   input wire                          arst_n_i,
   input wire                          stb_i,
   input wire                          ack_o,
   input wire                          m_cyc_o,
   input wire                          m_stb_o,
   input wire                          m_we_o,
   input wire  [`WB_CACHE_ADDR_W-2:0]  m_adr_o,
   input wire  [`WB_CACHE_DATA_W-1:0]  m_dat_o,
   input wire  [`WB_CACHE_SEL_W-1:0]   m_sel_o,
   input wire                          m_ack_i
);

   int fail_cnt = 0;

   // back-end transfer held until the slave acks
   stable_fields: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      (m_stb_o && !m_ack_i) |=> ($stable(m_we_o) && $stable(m_adr_o)
                                 && $stable(m_dat_o) && $stable(m_sel_o)))
      else begin
         fail_cnt++;
         $error("back-end transfer changed before m_ack_i");
      end

   stb_in_cycle: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      m_stb_o |-> m_cyc_o)
      else begin
         fail_cnt++;
         $error("m_stb_o high without m_cyc_o");
      end

   ack_with_stb: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      ack_o |-> stb_i)
      else begin
         fail_cnt++;
         $error("ack_o high without stb_i");
      end

   quiet_in_reset: assert property (@(posedge clk_i) !arst_n_i |-> !m_stb_o)
      else begin
         fail_cnt++;
         $error("m_stb_o high during reset");
      end

endmodule

bind wb_cache_top wb_cache_sva protocol_checks (
   .clk_i    (clk_i),
   .arst_n_i (arst_n_i),
   .stb_i    (stb_i),
   .ack_o    (ack_o),
   .m_cyc_o  (m_cyc_o),
   .m_stb_o  (m_stb_o),
   .m_we_o   (m_we_o),
   .m_adr_o  (m_adr_o),
   .m_dat_o  (m_dat_o),
   .m_sel_o  (m_sel_o),
   .m_ack_i  (m_ack_i)
);

`default_nettype wire

// ==== wb_cache_tb.sv ====
`default_nettype none
`include "wb_cache_config.svh"

module wb_cache_tb;

   import wb_cache_pkg::*;

   localparam int    MEM_WORDS    = 8192;
   localparam int    TIMEOUT      = 2000;
   localparam int    SEED         = 50;
   localparam int    ACK_LATENCY  = 2;
   localparam string PATTERN_FILE = "wb_cache_patterns.txt";
   localparam logic [31:0] MEM_FILL = 32'hCAFE_0000;

   logic                          clk_i = 1'b0;
   logic                          arst_n_i;
   logic                          cyc_i;
   logic                          stb_i;
   logic                          we_i;
   logic [`WB_CACHE_ADDR_W-1:0]   adr_i;
   logic [`WB_CACHE_DATA_W-1:0]   dat_i;
   logic [`WB_CACHE_SEL_W-1:0]    sel_i;
   wire  [`WB_CACHE_DATA_W-1:0]   dat_o;
   wire                           ack_o;
   wire                           m_cyc_o;
   wire                           m_stb_o;
   wire                           m_we_o;
   wire  [`WB_CACHE_ADDR_W-2:0]   m_adr_o;
   wire  [`WB_CACHE_DATA_W-1:0]   m_dat_o;
   wire  [`WB_CACHE_SEL_W-1:0]    m_sel_o;
   logic [`WB_CACHE_DATA_W-1:0]   m_dat_i = '0;
   logic                          m_ack_i = 1'b0;

   logic [31:0]  mem_model [0:MEM_WORDS-1];
   logic [1:0]   wait_cnt;
   integer       seed;
   int           err_cnt = 0;
   int           test_cnt = 0;
   bit           aborted = 1'b0;

   always #10 clk_i = ~clk_i;

   wb_cache_top UUT (
      .clk_i    (clk_i),
      .arst_n_i (arst_n_i),
      .cyc_i    (cyc_i),
      .stb_i    (stb_i),
      .we_i     (we_i),
      .adr_i    (adr_i),
      .dat_i    (dat_i),
      .sel_i    (sel_i),
      .dat_o    (dat_o),
      .ack_o    (ack_o),
      .m_cyc_o  (m_cyc_o),
      .m_stb_o  (m_stb_o),
      .m_we_o   (m_we_o),
      .m_adr_o  (m_adr_o),
      .m_dat_o  (m_dat_o),
      .m_sel_o  (m_sel_o),
      .m_dat_i  (m_dat_i),
      .m_ack_i  (m_ack_i)
   );

   // back-end memory with 0 to 3 wait states per transfer
   always @(posedge clk_i) begin
      if (!arst_n_i) begin
         // image reloaded while reset is held
         for (int a = 0; a < MEM_WORDS; a++) begin
            mem_model[a[12:0]] = a ^ MEM_FILL;
         end
         m_ack_i  <= 1'b0;
         wait_cnt <= 2'd0;
      end else if (m_ack_i) begin
         m_ack_i <= 1'b0;
      end else if (m_cyc_o && m_stb_o) begin
         if (wait_cnt != 2'd0) begin
            wait_cnt <= wait_cnt - 2'd1;
         end else begin
            if (m_we_o) begin
               for (int b = 0; b < `WB_CACHE_SEL_W; b++) begin
                  if (m_sel_o[b]) begin
                     mem_model[{2'b00, m_adr_o}][8*b +: 8] = m_dat_o[8*b +: 8];
                  end
               end
            end else begin
               m_dat_i <= mem_model[{2'b00, m_adr_o}];
            end
            m_ack_i  <= 1'b1;
            wait_cnt <= 2'($unsigned($random(seed)));
         end
      end
   end

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      if (expected !== actual) begin
         $display("error %0s: expected %08h, actual %08h", name, expected, actual);
         err_cnt++;
      end
   endtask

   // one front-end transfer held until ack_o
   task automatic bus_access(input logic we, input logic [11:0] adr, input logic [31:0] wdata,
                             input logic [3:0] sel, output logic [31:0] rdata,
                             output int latency);
      int cycles;
      rdata   = '0;
      latency = 0;
      cycles  = 0;
      @(posedge clk_i);
      cyc_i <= 1'b1;
      stb_i <= 1'b1;
      we_i  <= we;
      adr_i <= adr;
      dat_i <= wdata;
      sel_i <= sel;
      do begin
         @(posedge clk_i);
         cycles++;
      end while (!ack_o && cycles < TIMEOUT);
      if (ack_o) begin
         rdata = dat_o;
         // ack_o rose one edge before it was seen, counted from the edge that took the strobe
         latency = cycles - 2;
      end else begin
         $display("timeout: the cache gave no ack within %0d cycles at address %03h",
                  TIMEOUT, adr);
         aborted = 1'b1;
      end
      cyc_i <= 1'b0;
      stb_i <= 1'b0;
   endtask

   // polls STATUS until the write buffer reports empty
   task automatic wait_drained();
      logic [31:0] status;
      int          polls;
      int          latency;
      status = '0;
      polls  = 0;
      while (!status[0] && polls < TIMEOUT && !aborted) begin
         bus_access(1'b0, {1'b1, 11'(STATUS)}, '0, 4'hf, status, latency);
         polls++;
      end
      if (!status[0] && !aborted) begin
         $display("the write buffer did not drain within %0d status reads", TIMEOUT);
         aborted = 1'b1;
      end
   endtask

   function automatic string op_label(input logic [63:0] op);
      if (op == 64'("rd"))  return "read";
      if (op == 64'("wr"))  return "write";
      if (op == 64'("crd")) return "ctrl-read";
      if (op == 64'("cwr")) return "ctrl-write";
      if (op == 64'("chk")) return "mem-check";
      return "unknown";
   endfunction

   task automatic run_test(input logic [63:0] op, input logic [11:0] adr,
                           input logic [31:0] wdata, input logic [3:0] sel,
                           input logic [31:0] expected);
      string       name;
      int          errs_before;
      int          latency;
      logic [31:0] rdata;
      name        = $sformatf("%0d %0s %03h", test_cnt, op_label(op), adr);
      errs_before = err_cnt;
      latency     = 0;
      if (op == 64'("rd") || op == 64'("crd")) begin
         bus_access(1'b0, adr, '0, 4'hf, rdata, latency);
         if (!aborted) begin
            check_value(name, expected, rdata);
         end
      end else if (op == 64'("wr") || op == 64'("cwr")) begin
         bus_access(1'b1, adr, wdata, sel, rdata, latency);
      end else if (op == 64'("chk")) begin
         wait_drained();
         if (!aborted) begin
            check_value(name, expected, mem_model[{2'b00, adr[10:0]}]);
         end
      end else begin
         $display("test %0s has an opcode the testbench does not know", name);
         err_cnt++;
      end
      // control accesses always answer on the short path
      if ((op == 64'("crd") || op == 64'("cwr")) && !aborted) begin
         check_value({name, " ack latency"}, 32'(ACK_LATENCY), 32'(latency));
      end
      $display("test %0s %0s", name,
               (err_cnt == errs_before && !aborted) ? "passed" : "FAILED");
      test_cnt++;
   endtask

   initial begin
      int               fd;
      int               code;
      logic [63:0]      op;
      logic [11:0]      adr;
      logic [31:0]      wdata;
      logic [3:0]       sel;
      logic [31:0]      expected;
      logic [8*160-1:0] skip_line;

      seed = SEED;
      arst_n_i <= 1'b0;
      cyc_i    <= 1'b0;
      stb_i    <= 1'b0;
      we_i     <= 1'b0;
      adr_i    <= '0;
      dat_i    <= '0;
      sel_i    <= '0;
      repeat (16) @(posedge clk_i);
      arst_n_i <= 1'b1;

      fd = $fopen(PATTERN_FILE, "r");
      if (fd == 0) begin
         $display("cannot open the pattern file %0s", PATTERN_FILE);
         aborted = 1'b1;
      end else begin
         op   = '0;
         code = $fscanf(fd, "%s", op);
         while (code == 1 && !aborted) begin
            if (op == 64'("#")) begin
               code = $fgets(skip_line, fd);
            end else begin
               code = $fscanf(fd, "%h %h %h %h", adr, wdata, sel, expected);
               if (code == 4) begin
                  run_test(op, adr, wdata, sel, expected);
               end else begin
                  $display("pattern line for test %0d is incomplete", test_cnt);
                  aborted = 1'b1;
               end
            end
            op   = '0;
            code = $fscanf(fd, "%s", op);
         end
         $fclose(fd);
      end

      $display("%0d tests run, %0d errors, %0d assertion failures", test_cnt, err_cnt,
               UUT.protocol_checks.fail_cnt);
      if (err_cnt == 0 && !aborted && UUT.protocol_checks.fail_cnt == 0) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== wb_cache_patterns.txt ====
# op addr wdata sel expected, all hex; expected is the read data or the model memory word
# rd/wr memory space, crd/cwr control space at 800 and up, chk waits for drain then reads the model
rd  010 00000000 f CAFE0010
rd  010 00000000 f CAFE0010
rd  013 00000000 f CAFE0013
rd  011 00000000 f CAFE0011
wr  012 11223344 3 00000000
rd  012 00000000 f CAFE3344
wr  100 AABBCCDD c 00000000
rd  100 00000000 f AABB0100
chk 012 00000000 f CAFE3344
chk 100 00000000 f AABB0100
crd 801 00000000 f 00000004
crd 802 00000000 f 00000002
crd 803 00000000 f 00000001
crd 804 00000000 f 00000001
cwr 806 00000000 f 00000000
crd 801 00000000 f 00000000
crd 802 00000000 f 00000000
cwr 805 00000000 f 00000000
rd  012 00000000 f CAFE3344
crd 802 00000000 f 00000001
wr  020 11111111 f 00000000
wr  021 22222222 f 00000000
wr  022 33333333 f 00000000
wr  023 44444444 f 00000000
wr  024 55555555 f 00000000
wr  025 66666666 f 00000000
rd  022 00000000 f 33333333
rd  025 00000000 f 66666666
rd  021 00000000 f 22222222
crd 800 00000000 f 00000001
crd 801 00000000 f 00000001
crd 802 00000000 f 00000003
crd 803 00000000 f 00000000
crd 804 00000000 f 00000006
chk 024 00000000 f 55555555

// ==== wb_cache.f ====
+incdir+.
wb_cache_pkg.sv
wb_cache_if.sv
wb_cache_front_end.sv
wb_cache_memory.sv
wb_cache_wtbuf.sv
wb_cache_back_end.sv
wb_cache_control.sv
wb_cache_top.sv
wb_cache_sva.sv
wb_cache_tb.sv

// ==== run.sh ====
#!/bin/sh
# builds and runs the wb_cache testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -f wb_cache.f --top-module wb_cache_tb -o wb_cache_sim
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

out=$(./obj_dir/wb_cache_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if echo "$out" | grep -qx "Everything OK"; then
   exit 0
fi
exit 1
